//--- hw/fight_params.svh
`ifndef FIGHT_PARAMS_SVH
`define FIGHT_PARAMS_SVH

// Board clock runs at 60 Hz
`define FIGHT_TICK_DIV 60

// Seconds counter width
`define FIGHT_TIMER_W 7

// Countdown ends when the timer shows this value
`define FIGHT_COUNTDOWN_SECS 4

// Width of each player's health level
`define FIGHT_HEALTH_W 3

`endif

//--- hw/fight_pkg.sv
`include "fight_params.svh"

package fight_pkg;

  typedef enum logic [2:0] {
    idle      = 3'd0,
    countdown = 3'd1,
    fight     = 3'd2,
    p1_win    = 3'd3,
    p2_win    = 3'd4,
    draw      = 3'd5
  } game_state_e;

  typedef enum logic [2:0] {
    msg_1p     = 3'd0,
    msg_2p     = 3'd1,
    msg_count  = 3'd2,
    msg_fight  = 3'd3,
    msg_p1_win = 3'd4,
    msg_p2_win = 3'd5,
    msg_draw   = 3'd6
  } hex_msg_e;

  typedef enum logic [1:0] {
    timer_hold  = 2'b00,
    timer_count = 2'b01,
    timer_clear = 2'b11
  } timer_op_e;

  typedef struct packed {
    logic [`FIGHT_HEALTH_W-1:0] health1;
    logic [`FIGHT_HEALTH_W-1:0] health2;
  } player_health_t;

  // Active-low segments, bit order gfedcba
  typedef struct packed {
    logic [6:0] hex5;
    logic [6:0] hex4;
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;
  } hex_digits_t;

endpackage

//--- hw/second_tick.sv
`timescale 1ns/1ps
`include "fight_params.svh"

module second_tick (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  localparam int DIV   = `FIGHT_TICK_DIV;
  localparam int CNT_W = $clog2(DIV);

  logic [CNT_W-1:0] cnt;

  assign tick = (cnt == CNT_W'(DIV - 1)); // High on the wrap cycle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt <= '0;
    end else if (tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // A tick is a single-cycle strobe
  a_tick_single: assert property (@(posedge clk) disable iff (reset) tick |=> !tick);

endmodule

//--- hw/round_timer.sv
`timescale 1ns/1ps
`include "fight_params.svh"

module round_timer
  import fight_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      tick,
  input  timer_op_e                 timer_op,
  output logic [`FIGHT_TIMER_W-1:0] game_duration
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      game_duration <= '0;
    end else begin
      case (timer_op)
        timer_clear: game_duration <= '0;
        timer_count: begin
          if (tick) begin
            game_duration <= game_duration + 1'b1; // Wraps at full width
          end
        end
        default: game_duration <= game_duration; // Frozen on a result
      endcase
    end
  end

  // A held timer keeps its value across the next edge
  a_hold_stable: assert property (
    @(posedge clk) disable iff (reset)
    timer_op == timer_hold |=> $stable(game_duration)
  );

endmodule

//--- hw/match_fsm.sv
`timescale 1ns/1ps
`include "fight_params.svh"

module match_fsm
  import fight_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [3:0]                key,
  input  logic                      single_player,
  input  player_health_t            health,
  input  logic [`FIGHT_TIMER_W-1:0] game_duration,
  output game_state_e               game_state,
  output timer_op_e                 timer_op,
  output logic                      player_reset,
  output hex_msg_e                  hex_msg
);

  game_state_e next_state;
  logic        start_req;
  logic        p1_alive;
  logic        p2_alive;

  assign start_req = ~&key[3:1]; // Any of key[3:1] pressed
  assign p1_alive  = |health.health1;
  assign p2_alive  = |health.health2;

  always_comb begin
    next_state   = game_state;
    player_reset = 1'b1;
    hex_msg      = single_player ? msg_1p : msg_2p;
    case (game_state)
      idle: begin
        if (start_req) begin
          next_state = countdown;
        end
      end
      countdown: begin
        hex_msg = msg_count;
        if (game_duration == `FIGHT_TIMER_W'(`FIGHT_COUNTDOWN_SECS)) begin
          next_state = fight;
        end
      end
      fight: begin
        hex_msg      = msg_fight;
        player_reset = 1'b0; // Players active only here
        if (!p1_alive && p2_alive) begin
          next_state = p2_win;
        end else if (p1_alive && !p2_alive) begin
          next_state = p1_win;
        end else if (!p1_alive && !p2_alive) begin
          next_state = draw;
        end
      end
      p1_win, p2_win, draw: begin
        case (game_state)
          p1_win:  hex_msg = msg_p1_win;
          p2_win:  hex_msg = msg_p2_win;
          default: hex_msg = msg_draw;
        endcase
        player_reset = start_req; // Reset follows the key press
        if (start_req) begin
          next_state = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      game_state <= idle;
      timer_op   <= timer_clear;
    end else begin
      game_state <= next_state;
      if (next_state != game_state) begin
        case (next_state)
          countdown, fight:     timer_op <= timer_clear; // Fresh count per phase
          p1_win, p2_win, draw: timer_op <= timer_hold;
          default:              timer_op <= timer_clear;
        endcase
      end else begin
        case (game_state)
          countdown, fight:     timer_op <= timer_count;
          p1_win, p2_win, draw: timer_op <= timer_hold;
          default:              timer_op <= timer_clear;
        endcase
      end
    end
  end

  a_state_legal: assert property (
    @(posedge clk) disable iff (reset)
    game_state inside {idle, countdown, fight, p1_win, p2_win, draw}
  );

  // Fight is only reachable through the countdown
  a_fight_entry: assert property (
    @(posedge clk) disable iff (reset)
    $changed(game_state) && game_state == fight |-> $past(game_state) == countdown
  );

endmodule

//--- hw/hex_text.sv
`timescale 1ns/1ps
`include "fight_params.svh"

module hex_text
  import fight_pkg::*;
(
  input  hex_msg_e                  hex_msg,
  input  logic [`FIGHT_TIMER_W-1:0] game_duration,
  output hex_digits_t               hex
);

  // Letter font, active low gfedcba
  localparam logic [6:0] SEG_BLANK = 7'b1111111;
  localparam logic [6:0] SEG_P     = 7'b0001100;
  localparam logic [6:0] SEG_F     = 7'b0001110;
  localparam logic [6:0] SEG_I     = 7'b1001111; // Left bar
  localparam logic [6:0] SEG_G     = 7'b1000010;
  localparam logic [6:0] SEG_H     = 7'b0001001;
  localparam logic [6:0] SEG_W     = 7'b1000001; // Wide U shape
  localparam logic [6:0] SEG_N     = 7'b0101011;
  localparam logic [6:0] SEG_D     = 7'b0100001;
  localparam logic [6:0] SEG_R     = 7'b0101111;
  localparam logic [6:0] SEG_A     = 7'b0001000;

  logic [`FIGHT_TIMER_W-1:0] dur_mod;
  logic [3:0]                tens;
  logic [3:0]                ones;

  function automatic logic [6:0] seg_digit(input logic [3:0] d);
    case (d)
      4'd0:    seg_digit = 7'b1000000;
      4'd1:    seg_digit = 7'b1111001;
      4'd2:    seg_digit = 7'b0100100;
      4'd3:    seg_digit = 7'b0110000;
      4'd4:    seg_digit = 7'b0011001;
      4'd5:    seg_digit = 7'b0010010;
      4'd6:    seg_digit = 7'b0000010;
      4'd7:    seg_digit = 7'b1111000;
      4'd8:    seg_digit = 7'b0000000;
      4'd9:    seg_digit = 7'b0010000;
      default: seg_digit = SEG_BLANK;
    endcase
  endfunction

  assign dur_mod = game_duration % `FIGHT_TIMER_W'(100); // Two digits only
  assign tens    = 4'(dur_mod / 10);
  assign ones    = 4'(dur_mod % 10);

  always_comb begin
    hex = {6{SEG_BLANK}};
    case (hex_msg)
      msg_1p, msg_2p: begin
        hex.hex1 = seg_digit((hex_msg == msg_1p) ? 4'd1 : 4'd2);
        hex.hex0 = SEG_P;
      end
      msg_count: begin
        hex.hex1 = seg_digit(tens);
        hex.hex0 = seg_digit(ones);
      end
      msg_fight: begin
        hex.hex5 = SEG_F;
        hex.hex4 = SEG_I;
        hex.hex3 = SEG_G;
        hex.hex2 = SEG_H;
        hex.hex1 = seg_digit(tens);
        hex.hex0 = seg_digit(ones);
      end
      msg_p1_win, msg_p2_win: begin
        hex.hex5 = SEG_P;
        hex.hex4 = seg_digit((hex_msg == msg_p1_win) ? 4'd1 : 4'd2);
        hex.hex2 = SEG_W;
        hex.hex1 = SEG_I;
        hex.hex0 = SEG_N;
      end
      msg_draw: begin
        hex.hex5 = SEG_D;
        hex.hex4 = SEG_R;
        hex.hex3 = SEG_A;
        hex.hex2 = SEG_W;
      end
      default: hex = {6{SEG_BLANK}};
    endcase
  end

endmodule

//--- hw/fight_match_top.sv
`timescale 1ns/1ps
`include "fight_params.svh"

module fight_match_top
  import fight_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [3:0]                key,     // Active low
  input  logic [9:0]                sw,
  input  player_health_t            health,
  output hex_digits_t               hex,
  output logic                      player_reset,
  output game_state_e               game_state,
  output logic [`FIGHT_TIMER_W-1:0] game_duration
);

  logic      tick;
  timer_op_e timer_op;
  hex_msg_e  hex_msg;

  second_tick u_second_tick (
    .clk   (clk),
    .reset (reset),
    .tick  (tick)
  );

  round_timer u_round_timer (
    .clk           (clk),
    .reset         (reset),
    .tick          (tick),
    .timer_op      (timer_op),
    .game_duration (game_duration)
  );

  match_fsm u_match_fsm (
    .clk           (clk),
    .reset         (reset),
    .key           (key),
    .single_player (sw[0]), // Mode switch
    .health        (health),
    .game_duration (game_duration),
    .game_state    (game_state),
    .timer_op      (timer_op),
    .player_reset  (player_reset),
    .hex_msg       (hex_msg)
  );

  hex_text u_hex_text (
    .hex_msg       (hex_msg),
    .game_duration (game_duration),
    .hex           (hex)
  );

endmodule

//--- bench/fight_match_tb.sv
`timescale 1ns/1ps
`include "fight_params.svh"

module fight_match_tb
  import fight_pkg::*;
();

  localparam int TICK_DIV       = `FIGHT_TICK_DIV;
  localparam int TIMEOUT_CYCLES = 6000; // Four rounds of about 700 cycles plus margin

  // Active-low gfedcba glyphs
  localparam logic [6:0] DIGIT_GLYPH [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                                               7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
  localparam logic [6:0] G_BLANK = 7'b1111111;
  localparam logic [6:0] G_P     = 7'b0001100;
  localparam logic [6:0] G_F     = 7'b0001110;
  localparam logic [6:0] G_I     = 7'b1001111;
  localparam logic [6:0] G_G     = 7'b1000010;
  localparam logic [6:0] G_H     = 7'b0001001;
  localparam logic [6:0] G_W     = 7'b1000001;
  localparam logic [6:0] G_N     = 7'b0101011;
  localparam logic [6:0] G_D     = 7'b0100001;
  localparam logic [6:0] G_R     = 7'b0101111;
  localparam logic [6:0] G_A     = 7'b0001000;

  logic                      clk;
  logic                      reset;
  logic [3:0]                key;
  logic [9:0]                sw;
  player_health_t            health;
  hex_digits_t               hex;
  logic                      player_reset;
  game_state_e               game_state;
  logic [`FIGHT_TIMER_W-1:0] game_duration;

  game_state_e               exp_state;    // Reference model of the round FSM
  logic [`FIGHT_TIMER_W-1:0] last_dur;
  int                        since_change; // Cycles since game_duration last moved
  int                        cycle_count = 0;
  integer                    seed;

  fight_match_top u_fight_match_top (
    .clk           (clk),
    .reset         (reset),
    .key           (key),
    .sw            (sw),
    .health        (health),
    .hex           (hex),
    .player_reset  (player_reset),
    .game_state    (game_state),
    .game_duration (game_duration)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic hex_digits_t expected_hex(input game_state_e st, input logic one_player,
                                               input logic [`FIGHT_TIMER_W-1:0] dur);
    int         v;
    logic [6:0] tens_g;
    logic [6:0] ones_g;
    v      = int'(dur) % 100;
    tens_g = DIGIT_GLYPH[v / 10];
    ones_g = DIGIT_GLYPH[v % 10];
    case (st)
      idle:      expected_hex = {{4{G_BLANK}}, DIGIT_GLYPH[one_player ? 1 : 2], G_P};
      countdown: expected_hex = {{4{G_BLANK}}, tens_g, ones_g};
      fight:     expected_hex = {G_F, G_I, G_G, G_H, tens_g, ones_g};
      p1_win:    expected_hex = {G_P, DIGIT_GLYPH[1], G_BLANK, G_W, G_I, G_N};
      p2_win:    expected_hex = {G_P, DIGIT_GLYPH[2], G_BLANK, G_W, G_I, G_N};
      default:   expected_hex = {G_D, G_R, G_A, G_W, G_BLANK, G_BLANK};
    endcase
  endfunction

  function automatic logic expected_player_reset(input game_state_e st, input logic [3:0] k);
    case (st)
      idle, countdown: expected_player_reset = 1'b1;
      fight:           expected_player_reset = 1'b0;
      default:         expected_player_reset = ~&k[3:1]; // Only while a key is held
    endcase
  endfunction

  function automatic logic [2:0] random_health();
    random_health = 3'(1 + {$random(seed)} % 7); // Never zero
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    abort_run($sformatf("MISMATCH %s expected %0h actual %0h", name, expected, actual));
  endtask

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exp_state    <= idle;
      last_dur     <= '0;
      since_change <= 0;
    end else begin
      last_dur     <= game_duration;
      since_change <= (game_duration != last_dur) ? 1 : since_change + 1;
      case (exp_state)
        idle:      if (~&key[3:1]) exp_state <= countdown;
        countdown: if (game_duration == `FIGHT_COUNTDOWN_SECS) exp_state <= fight;
        fight: begin
          if (health.health1 == 0 && health.health2 == 0) exp_state <= draw;
          else if (health.health1 == 0) exp_state <= p2_win;
          else if (health.health2 == 0) exp_state <= p1_win;
        end
        default:   if (~&key[3:1]) exp_state <= idle;
      endcase
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the rounds did not finish within the cycle limit");
    end
  end

  a_state: assert property (@(posedge clk) disable iff (reset) game_state == exp_state)
    else report_mismatch("game_state", 64'($sampled(exp_state)), 64'($sampled(game_state)));

  a_player_reset: assert property (@(posedge clk) disable iff (reset)
    player_reset == expected_player_reset(game_state, key))
    else report_mismatch("player_reset",
                         64'(expected_player_reset($sampled(game_state), $sampled(key))),
                         64'($sampled(player_reset)));

  a_hex: assert property (@(posedge clk) disable iff (reset)
    hex == expected_hex(game_state, sw[0], game_duration))
    else report_mismatch("hex", 64'(expected_hex($sampled(game_state), $sampled(sw[0]),
                         $sampled(game_duration))), 64'($sampled(hex)));

  a_idle_zero: assert property (@(posedge clk) disable iff (reset)
    game_state == idle && $past(game_state) == idle |-> game_duration == 0)
    else report_mismatch("game_duration", 64'(0), 64'($sampled(game_duration)));

  a_step_one: assert property (@(posedge clk) disable iff (reset)
    $changed(game_duration) && game_duration != 0 |-> game_duration == $past(game_duration) + 1'b1)
    else report_mismatch("game_duration", 64'($sampled(last_dur) + 1'b1),
                         64'($sampled(game_duration)));

  a_step_gap: assert property (@(posedge clk) disable iff (reset)
    $changed(game_duration) && game_duration != 0 && $past(game_duration) != 0
    |-> since_change >= TICK_DIV)
    else abort_run("Timer stepped sooner than one second after its previous step");

  a_fight_clear: assert property (@(posedge clk) disable iff (reset)
    $rose(game_state == fight) |-> ##[0:1] game_duration == 0)
    else abort_run("Timer was not cleared after entering fight");

  a_result_frozen: assert property (@(posedge clk) disable iff (reset)
    game_state inside {p1_win, p2_win, draw} && $past(game_state) == game_state
    |-> $stable(game_duration))
    else abort_run("Timer moved while a result was shown");

  a_fight_holds: assert property (@(posedge clk) disable iff (reset)
    game_state == fight && health.health1 != 0 && health.health2 != 0 |=> game_state == fight)
    else abort_run("Fight ended while both players still had health");

  task automatic press_key(input int idx);
    key[idx] = 1'b0;
    @(negedge clk);
    key = 4'hf; // Released before the next state can react
  endtask

  task automatic wait_for_state(input game_state_e st);
    while (game_state != st) @(negedge clk);
  endtask

  task automatic play_round(input logic one_player, input int start_key,
                            input logic [2:0] end_h1, input logic [2:0] end_h2,
                            input game_state_e result, input int leave_key);
    sw[0] = one_player;
    repeat (20) @(negedge clk);
    press_key(start_key);
    wait_for_state(fight);
    repeat (150) begin
      health.health1 = random_health();
      health.health2 = random_health();
      @(negedge clk);
    end
    health.health1 = end_h1;
    health.health2 = end_h2;
    wait_for_state(result);
    repeat (100) @(negedge clk);
    press_key(leave_key);
    health = '{health1: 3'd7, health2: 3'd7};
    wait_for_state(idle);
  endtask

  initial begin
    seed   = 85;
    reset  = 1'b1;
    key    = 4'hf;
    sw     = 10'h001;
    health = '{health1: 3'd7, health2: 3'd7};
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (5) @(negedge clk);
    press_key(0); // Unused key must not start a round
    play_round(1'b1, 1, 3'd0, 3'd5, p2_win, 2);
    play_round(1'b0, 2, 3'd3, 3'd0, p1_win, 3);
    play_round(1'b1, 3, 3'd0, 3'd0, draw, 1);
    play_round(1'b0, 1, 3'd0, 3'd2, p2_win, 3);
    repeat (10) @(negedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
hw/fight_pkg.sv
hw/second_tick.sv
hw/round_timer.sv
hw/match_fsm.sv
hw/hex_text.sv
hw/fight_match_top.sv
bench/fight_match_tb.sv

//--- Bender.yml
package:
  name: fight_match

sources:
  - include_dirs:
      - hw
    files:
      - hw/fight_pkg.sv
      - hw/second_tick.sv
      - hw/round_timer.sv
      - hw/match_fsm.sv
      - hw/hex_text.sv
      - hw/fight_match_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/fight_match_tb.sv
